// File: verilog.f
source/ebiu_axi_pkg.sv
source/ebiu_rd_pkg.sv
source/ebiu_ar_arbiter.sv
source/ebiu_ar_buffer.sv
source/ebiu_r_fifo.sv
source/ebiu_r_return.sv
source/ebiu_rd_channel.sv
test/ebiu_rd_properties.sv
test/tb_ebiu_rd_channel.sv

// File: test/tb_ebiu_rd_channel.sv
/*
  Testbench for the read channel: clock, reset, AXI slave model,
  directed tests of routing, arbitration, back-pressure and rack
*/
`timescale 1ns/1ps
`default_nettype none

module tb_ebiu_rd_channel;

  localparam int RFIFO_DEPTH = 2;
  localparam int SNB_ENTRIES = 24;
  // Six tests take about 300 cycles
  localparam int CYCLE_LIMIT = 2000;

  logic                   arctrl_clk;
  logic                   cpurst_b;
  logic                   ncq_valid;
  ebiu_rd_pkg::rd_req_t   ncq_req;
  ebiu_rd_pkg::ncq_id_t   ncq_id;
  logic                   ncq_ar_grant;
  logic                   snb_valid;
  ebiu_rd_pkg::rd_req_t   snb_req;
  ebiu_rd_pkg::sub_id_t   snb_id;
  logic                   snb_ar_grant;
  logic                   ctc_valid;
  ebiu_rd_pkg::rd_req_t   ctc_req;
  ebiu_rd_pkg::sub_id_t   ctc_id;
  logic                   ctc_ar_grant;
  logic                   ncq_rvalid;
  ebiu_axi_pkg::axi_id_t  ncq_rid;
  logic                   snb0_rvalid;
  logic                   snb1_rvalid;
  logic [SNB_ENTRIES-1:0] snb_entry_sel;
  logic                   ctc_rvalid;
  ebiu_rd_pkg::sub_id_t   ctc_rid;
  ebiu_axi_pkg::r_beat_t  ret_beat;
  logic                   ncq_r_grant;
  logic                   snb_r_grant;
  logic                   ctc_r_grant;
  logic                   arvalid;
  ebiu_axi_pkg::ar_chan_t ar;
  logic                   arready;
  logic                   rvalid = 1'b0;
  ebiu_axi_pkg::r_beat_t  r_in = '0;
  logic                   rready;
  logic                   rack;

  // Slave model state
  integer                 seed = 32'h7c99a98f;
  integer                 rnd;
  ebiu_axi_pkg::ar_chan_t ar_q[$];
  ebiu_axi_pkg::ar_chan_t ar_log[$];
  ebiu_axi_pkg::r_beat_t  exp_q[$];
  ebiu_axi_pkg::ar_chan_t cur_ar;
  ebiu_axi_pkg::r_beat_t  next_beat;
  int                     beats_left = 0;
  int                     rack_cycles = 0;
  int                     lasts_granted = 0;
  int                     cycles = 0;

  ebiu_rd_channel #(
    .RFIFO_DEPTH (RFIFO_DEPTH),
    .SNB_ENTRIES (SNB_ENTRIES)
  ) DUT (
    .arctrl_clk (arctrl_clk), .cpurst_b (cpurst_b),
    .ncq_valid (ncq_valid), .ncq_req (ncq_req), .ncq_id (ncq_id),
    .ncq_ar_grant (ncq_ar_grant),
    .snb_valid (snb_valid), .snb_req (snb_req), .snb_id (snb_id),
    .snb_ar_grant (snb_ar_grant),
    .ctc_valid (ctc_valid), .ctc_req (ctc_req), .ctc_id (ctc_id),
    .ctc_ar_grant (ctc_ar_grant),
    .ncq_rvalid (ncq_rvalid), .ncq_rid (ncq_rid),
    .snb0_rvalid (snb0_rvalid), .snb1_rvalid (snb1_rvalid),
    .snb_entry_sel (snb_entry_sel),
    .ctc_rvalid (ctc_rvalid), .ctc_rid (ctc_rid), .ret_beat (ret_beat),
    .ncq_r_grant (ncq_r_grant), .snb_r_grant (snb_r_grant), .ctc_r_grant (ctc_r_grant),
    .arvalid (arvalid), .ar (ar), .arready (arready),
    .rvalid (rvalid), .r_in (r_in), .rready (rready), .rack (rack)
  );

  bind ebiu_rd_channel ebiu_rd_properties u_rd_props (
    .arctrl_clk  (arctrl_clk),
    .cpurst_b    (cpurst_b),
    .arvalid     (arvalid),
    .arready     (arready),
    .ar          (ar),
    .ncq_rvalid  (ncq_rvalid),
    .snb0_rvalid (snb0_rvalid),
    .snb1_rvalid (snb1_rvalid),
    .ctc_rvalid  (ctc_rvalid),
    .rready      (rready),
    .head_valid  (head_valid)
  );

  initial
  begin
    arctrl_clk = 1'b0;
    forever #2 arctrl_clk = ~arctrl_clk;
  end

  // ------------------------------
  // Failure reporting
  // ------------------------------
  task automatic end_in_failure();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [159:0] exp,
                                 input logic [159:0] got);
    $display("Fail %s expected %0h got %0h", name, exp, got);
    end_in_failure();
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    end_in_failure();
  endtask

  always @(posedge arctrl_clk)
  begin
    cycles++;
    if (cpurst_b && rack)
      rack_cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
      end_in_failure();
    end
  end

  // ------------------------------
  // AXI slave model
  // ------------------------------
  // In-order beats, len+1 per AR, new beat once the current one is taken
  always @(posedge arctrl_clk)
  begin
    if (arvalid && arready)
    begin
      ar_q.push_back(ar);
      ar_log.push_back(ar);
    end
    if (rvalid && rready)
      exp_q.push_back(r_in);
    if (!rvalid || rready)
    begin
      if (beats_left == 0 && ar_q.size() > 0)
      begin
        cur_ar     = ar_q.pop_front();
        beats_left = cur_ar.len + 1;
      end
      if (beats_left > 0)
      begin
        rnd            = $random(seed);
        next_beat.id   = cur_ar.id;
        next_beat.resp = rnd[1:0];
        next_beat.last = (beats_left == 1);
        next_beat.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
        beats_left--;
        r_in   <= next_beat;
        rvalid <= 1'b1;
      end
      else
        rvalid <= 1'b0;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic ebiu_rd_pkg::rd_req_t make_req(input ebiu_axi_pkg::addr_t addr,
                                                    input ebiu_axi_pkg::len_t len);
    ebiu_rd_pkg::rd_req_t req;
    req.addr  = addr;
    req.len   = len;
    req.size  = 3'd4;
    req.burst = 2'b01;
    req.lock  = 1'b0;
    req.cache = 4'h3;
    // Outer prot bits vary with len, bit 1 always requested clear
    req.prot  = {len[0], 1'b0, !len[0]};
    return req;
  endfunction

  // Expected requester bits {ncq, snb0, snb1, ctc} for an ID
  function automatic logic [3:0] expected_route(input ebiu_axi_pkg::axi_id_t id);
    if (!id[7])
      return 4'b1000;
    else if (!id[6])
      return id[5] ? 4'b0010 : 4'b0100;
    else
      return 4'b0001;
  endfunction

  task automatic apply_reset();
    repeat (8) @(posedge arctrl_clk);
    cpurst_b <= 1'b1;
    @(posedge arctrl_clk);
    assert (!arvalid) else report_mismatch("arvalid", 0, arvalid);
    assert (!rack) else report_mismatch("rack", 0, rack);
    assert (rready) else report_mismatch("rready", 1, rready);
    assert ({ncq_rvalid, snb0_rvalid, snb1_rvalid, ctc_rvalid} == 4'b0000)
      else report_mismatch("rvalid", 0, {ncq_rvalid, snb0_rvalid, snb1_rvalid, ctc_rvalid});
  endtask

  // src 0 ncq, 1 snb, 2 ctc; checks the AR one cycle after the grant
  task automatic issue_request(input int src, input logic [6:0] id,
                               input ebiu_rd_pkg::rd_req_t req,
                               input ebiu_axi_pkg::axi_id_t exp_id);
    logic                granted;
    ebiu_axi_pkg::prot_t exp_prot;
    granted  = 1'b0;
    exp_prot = req.prot | 3'b010;
    case (src)
      0:
      begin
        ncq_valid <= 1'b1;
        ncq_req   <= req;
        ncq_id    <= id;
      end
      1:
      begin
        snb_valid <= 1'b1;
        snb_req   <= req;
        snb_id    <= id[5:0];
      end
      default:
      begin
        ctc_valid <= 1'b1;
        ctc_req   <= req;
        ctc_id    <= id[5:0];
      end
    endcase
    while (!granted)
    begin
      @(posedge arctrl_clk);
      granted = (src == 0) ? ncq_ar_grant : (src == 1) ? snb_ar_grant : ctc_ar_grant;
    end
    case (src)
      0: ncq_valid <= 1'b0;
      1: snb_valid <= 1'b0;
      default: ctc_valid <= 1'b0;
    endcase
    @(posedge arctrl_clk);
    assert (arvalid) else report_mismatch("arvalid", 1, arvalid);
    assert (ar.id == exp_id) else report_mismatch("ar.id", exp_id, ar.id);
    assert (ar.addr == req.addr) else report_mismatch("ar.addr", req.addr, ar.addr);
    assert (ar.len == req.len) else report_mismatch("ar.len", req.len, ar.len);
    assert (ar.size == req.size) else report_mismatch("ar.size", req.size, ar.size);
    assert (ar.burst == req.burst) else report_mismatch("ar.burst", req.burst, ar.burst);
    assert (ar.lock == req.lock) else report_mismatch("ar.lock", req.lock, ar.lock);
    assert (ar.cache == req.cache) else report_mismatch("ar.cache", req.cache, ar.cache);
    assert (ar.prot == exp_prot) else report_mismatch("ar.prot", exp_prot, ar.prot);
  endtask

  // Grants each beat one cycle after its rvalid is seen
  task automatic take_beats(input int count);
    ebiu_axi_pkg::r_beat_t  exp_beat;
    logic [3:0]             route;
    logic [SNB_ENTRIES-1:0] exp_sel;
    int                     taken;
    int                     i;
    taken = 0;
    while (taken < count)
    begin
      @(posedge arctrl_clk);
      if (ncq_rvalid | snb0_rvalid | snb1_rvalid | ctc_rvalid)
      begin
        assert (exp_q.size() > 0)
          else report_problem("Requester rvalid high with no beat accepted from the bus");
        exp_beat = exp_q.pop_front();
        route    = expected_route(exp_beat.id);
        assert ({ncq_rvalid, snb0_rvalid, snb1_rvalid, ctc_rvalid} == route)
          else report_mismatch("rvalid", route,
                               {ncq_rvalid, snb0_rvalid, snb1_rvalid, ctc_rvalid});
        assert (ret_beat == exp_beat) else report_mismatch("ret_beat", exp_beat, ret_beat);
        if (route[3])
        begin
          assert (ncq_rid == exp_beat.id) else report_mismatch("ncq_rid", exp_beat.id, ncq_rid);
          ncq_r_grant <= 1'b1;
        end
        else if (route[0])
        begin
          assert (ctc_rid == exp_beat.id[5:0])
            else report_mismatch("ctc_rid", exp_beat.id[5:0], ctc_rid);
          ctc_r_grant <= 1'b1;
        end
        else
        begin
          for (i = 0; i < SNB_ENTRIES; i++)
            exp_sel[i] = (i == exp_beat.id[4:0]);
          assert (snb_entry_sel == exp_sel)
            else report_mismatch("snb_entry_sel", exp_sel, snb_entry_sel);
          snb_r_grant <= 1'b1;
        end
        @(posedge arctrl_clk);
        ncq_r_grant <= 1'b0;
        snb_r_grant <= 1'b0;
        ctc_r_grant <= 1'b0;
        taken++;
        if (exp_beat.last)
          lasts_granted++;
      end
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic single_ncq_read();
    assert (!arvalid) else report_mismatch("arvalid", 0, arvalid);
    issue_request(0, 7'h2a, make_req(40'h12_3456_7890, 8'd3), 8'h2a);
    take_beats(4);
  endtask

  task automatic snb_entry_routing();
    issue_request(1, 7'h05, make_req(40'h00_0000_4400, 8'd1), 8'h85);
    issue_request(1, 7'h33, make_req(40'h00_0000_4800, 8'd2), 8'hb3);
    take_beats(5);
  endtask

  task automatic ctc_tagging();
    issue_request(2, 7'h2e, make_req(40'h80_0000_0040, 8'd1), 8'hee);
    take_beats(2);
  endtask

  task automatic three_way_arbitration();
    ebiu_axi_pkg::axi_id_t order[$];
    logic [2:0]            done;
    int                    i;
    done = 3'b000;
    ar_log.delete();
    ncq_valid <= 1'b1;
    ncq_id    <= 7'h11;
    ncq_req   <= make_req(40'h00_0000_1000, 8'd1);
    snb_valid <= 1'b1;
    snb_id    <= 6'h0a;
    snb_req   <= make_req(40'h00_0000_2000, 8'd0);
    ctc_valid <= 1'b1;
    ctc_id    <= 6'h15;
    ctc_req   <= make_req(40'h00_0000_3000, 8'd2);
    while (done != 3'b111)
    begin
      @(posedge arctrl_clk);
      if (ncq_ar_grant)
      begin
        assert (!done[0]) else report_problem("ncq granted more than once");
        done[0] = 1'b1;
        order.push_back(8'h11);
        ncq_valid <= 1'b0;
      end
      if (snb_ar_grant)
      begin
        assert (!done[1]) else report_problem("snb granted more than once");
        done[1] = 1'b1;
        order.push_back(8'h8a);
        snb_valid <= 1'b0;
      end
      if (ctc_ar_grant)
      begin
        assert (!done[2]) else report_problem("ctc granted more than once");
        done[2] = 1'b1;
        order.push_back(8'hd5);
        ctc_valid <= 1'b0;
      end
    end
    while (ar_log.size() < 3)
      @(posedge arctrl_clk);
    for (i = 0; i < 3; i++)
      assert (ar_log[i].id == order[i]) else report_mismatch("ar.id", order[i], ar_log[i].id);
    take_beats(6);
  endtask

  task automatic back_pressure();
    ebiu_axi_pkg::ar_chan_t held;
    arready <= 1'b0;
    issue_request(0, 7'h40, make_req(40'h00_0001_0000, 8'd3), 8'h40);
    held = ar;
    snb_valid <= 1'b1;
    snb_id    <= 6'h21;
    snb_req   <= make_req(40'h00_0001_0100, 8'd1);
    repeat (6)
    begin
      @(posedge arctrl_clk);
      assert (!snb_ar_grant) else report_problem("snb granted while arready was low");
      assert (arvalid) else report_mismatch("arvalid", 1, arvalid);
      assert (ar == held) else report_mismatch("ar", held, ar);
    end
    arready <= 1'b1;
    @(posedge arctrl_clk);
    while (!snb_ar_grant)
      @(posedge arctrl_clk);
    snb_valid <= 1'b0;
    // No r_grants yet, so the FIFO fills
    while (rready)
      @(posedge arctrl_clk);
    assert (exp_q.size() == RFIFO_DEPTH)
      else report_mismatch("beats held", RFIFO_DEPTH, exp_q.size());
    repeat (5)
    begin
      @(posedge arctrl_clk);
      assert (!rready) else report_mismatch("rready", 0, rready);
      assert (exp_q.size() == RFIFO_DEPTH)
        else report_mismatch("beats held", RFIFO_DEPTH, exp_q.size());
    end
    take_beats(6);
    assert (exp_q.size() == 0) else report_problem("Beats left over after back-pressure");
  endtask

  task automatic rack_counting();
    issue_request(0, 7'h05, make_req(40'h00_0002_0000, 8'd0), 8'h05);
    issue_request(1, 7'h17, make_req(40'h00_0002_0040, 8'd0), 8'h97);
    issue_request(2, 7'h3f, make_req(40'h00_0002_0080, 8'd0), 8'hff);
    take_beats(3);
    // Last rack pulse ends two cycles after its pop
    repeat (4) @(posedge arctrl_clk);
    assert (rack_cycles == lasts_granted)
      else report_mismatch("rack cycles", lasts_granted, rack_cycles);
    assert (!rack) else report_mismatch("rack", 0, rack);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    cpurst_b    = 1'b0;
    ncq_valid   = 1'b0;
    ncq_req     = '0;
    ncq_id      = '0;
    snb_valid   = 1'b0;
    snb_req     = '0;
    snb_id      = '0;
    ctc_valid   = 1'b0;
    ctc_req     = '0;
    ctc_id      = '0;
    ncq_r_grant = 1'b0;
    snb_r_grant = 1'b0;
    ctc_r_grant = 1'b0;
    arready     = 1'b1;
    apply_reset();
    single_ncq_read();
    snb_entry_routing();
    ctc_tagging();
    three_way_arbitration();
    back_pressure();
    rack_counting();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/ebiu_rd_properties.sv
/*
  Bound checks on AR stability, return valids and rready
*/
`timescale 1ns/1ps
`default_nettype none

module ebiu_rd_properties (
  input wire                         arctrl_clk,
  input wire                         cpurst_b,
  input wire                         arvalid,
  input wire                         arready,
  input wire ebiu_axi_pkg::ar_chan_t ar,
  input wire                         ncq_rvalid,
  input wire                         snb0_rvalid,
  input wire                         snb1_rvalid,
  input wire                         ctc_rvalid,
  input wire                         rready,
  input wire                         head_valid
);

  // Stalled AR holds valid and payload
  ar_held: assert property (@(posedge arctrl_clk) disable iff (!cpurst_b)
    arvalid && !arready |=> arvalid && $stable(ar))
    else $error("AR payload or arvalid changed while arready was low");

  one_return: assert property (@(posedge arctrl_clk) disable iff (!cpurst_b)
    $onehot0({ncq_rvalid, snb0_rvalid, snb1_rvalid, ctc_rvalid}))
    else $error("More than one requester rvalid high in the same cycle");

  // rready only drops with beats waiting
  rready_low: assert property (@(posedge arctrl_clk) disable iff (!cpurst_b)
    !rready |-> head_valid)
    else $error("rready low while the read FIFO is empty");

endmodule

`default_nettype wire

// File: source/ebiu_rd_channel.sv
/*
  Read channel top level: arbiter, AR buffer, R FIFO, return stage
*/
`timescale 1ns/1ps
`default_nettype none

module ebiu_rd_channel #(
  parameter int RFIFO_DEPTH = 2,
  parameter int SNB_ENTRIES = 24
) (
  input  wire                         arctrl_clk,
  input  wire                         cpurst_b,
  // Requesters, address side
  input  wire                         ncq_valid,
  input  wire ebiu_rd_pkg::rd_req_t   ncq_req,
  input  wire ebiu_rd_pkg::ncq_id_t   ncq_id,
  output logic                        ncq_ar_grant,
  input  wire                         snb_valid,
  input  wire ebiu_rd_pkg::rd_req_t   snb_req,
  input  wire ebiu_rd_pkg::sub_id_t   snb_id,
  output logic                        snb_ar_grant,
  input  wire                         ctc_valid,
  input  wire ebiu_rd_pkg::rd_req_t   ctc_req,
  input  wire ebiu_rd_pkg::sub_id_t   ctc_id,
  output logic                        ctc_ar_grant,
  // Requesters, return side
  output logic                        ncq_rvalid,
  output ebiu_axi_pkg::axi_id_t       ncq_rid,
  output logic                        snb0_rvalid,
  output logic                        snb1_rvalid,
  output logic [SNB_ENTRIES-1:0]      snb_entry_sel,
  output logic                        ctc_rvalid,
  output ebiu_rd_pkg::sub_id_t        ctc_rid,
  output ebiu_axi_pkg::r_beat_t       ret_beat,
  input  wire                         ncq_r_grant,
  input  wire                         snb_r_grant,
  input  wire                         ctc_r_grant,
  // AXI read channels
  output logic                        arvalid,
  output ebiu_axi_pkg::ar_chan_t      ar,
  input  wire                         arready,
  input  wire                         rvalid,
  input  wire ebiu_axi_pkg::r_beat_t  r_in,
  output logic                        rready,
  output logic                        rack
);

  wire ebiu_rd_pkg::src_sel_t  sel;
  wire ebiu_rd_pkg::rd_req_t   sel_req;
  wire                         buf_ready;
  wire                         head_valid;
  wire ebiu_axi_pkg::r_beat_t  head;
  wire                         pop;

  // ------------------------------
  // Address side
  // ------------------------------
  ebiu_ar_arbiter u_ar_arbiter (
    .arctrl_clk   (arctrl_clk),
    .cpurst_b     (cpurst_b),
    .ncq_valid    (ncq_valid),
    .snb_valid    (snb_valid),
    .ctc_valid    (ctc_valid),
    .ncq_req      (ncq_req),
    .snb_req      (snb_req),
    .ctc_req      (ctc_req),
    .buf_ready    (buf_ready),
    .ncq_ar_grant (ncq_ar_grant),
    .snb_ar_grant (snb_ar_grant),
    .ctc_ar_grant (ctc_ar_grant),
    .sel          (sel),
    .sel_req      (sel_req)
  );

  ebiu_ar_buffer u_ar_buffer (
    .arctrl_clk (arctrl_clk),
    .cpurst_b   (cpurst_b),
    .sel        (sel),
    .sel_req    (sel_req),
    .ncq_id     (ncq_id),
    .snb_id     (snb_id),
    .ctc_id     (ctc_id),
    .buf_ready  (buf_ready),
    .arvalid    (arvalid),
    .ar         (ar),
    .arready    (arready)
  );

  // ------------------------------
  // Data side
  // ------------------------------
  ebiu_r_fifo #(
    .RFIFO_DEPTH (RFIFO_DEPTH)
  ) u_r_fifo (
    .arctrl_clk (arctrl_clk),
    .cpurst_b   (cpurst_b),
    .rvalid     (rvalid),
    .r_in       (r_in),
    .rready     (rready),
    .head_valid (head_valid),
    .head       (head),
    .pop        (pop)
  );

  ebiu_r_return #(
    .SNB_ENTRIES (SNB_ENTRIES)
  ) u_r_return (
    .arctrl_clk    (arctrl_clk),
    .cpurst_b      (cpurst_b),
    .head_valid    (head_valid),
    .head          (head),
    .pop           (pop),
    .ncq_rvalid    (ncq_rvalid),
    .snb0_rvalid   (snb0_rvalid),
    .snb1_rvalid   (snb1_rvalid),
    .ctc_rvalid    (ctc_rvalid),
    .ncq_rid       (ncq_rid),
    .ctc_rid       (ctc_rid),
    .snb_entry_sel (snb_entry_sel),
    .ret_beat      (ret_beat),
    .ncq_r_grant   (ncq_r_grant),
    .snb_r_grant   (snb_r_grant),
    .ctc_r_grant   (ctc_r_grant),
    .rack          (rack)
  );

endmodule

`default_nettype wire

// File: source/ebiu_r_return.sv
/*
  Return routing of the FIFO head by ID, and rack generation
*/
`timescale 1ns/1ps
`default_nettype none

module ebiu_r_return #(
  parameter int SNB_ENTRIES = 24
) (
  input  wire                         arctrl_clk,
  input  wire                         cpurst_b,
  input  wire                         head_valid,
  input  wire ebiu_axi_pkg::r_beat_t  head,
  output logic                        pop,
  output logic                        ncq_rvalid,
  output logic                        snb0_rvalid,
  output logic                        snb1_rvalid,
  output logic                        ctc_rvalid,
  output ebiu_axi_pkg::axi_id_t       ncq_rid,
  output ebiu_rd_pkg::sub_id_t        ctc_rid,
  output logic [SNB_ENTRIES-1:0]      snb_entry_sel,
  output ebiu_axi_pkg::r_beat_t       ret_beat,
  input  wire                         ncq_r_grant,
  input  wire                         snb_r_grant,
  input  wire                         ctc_r_grant,
  output logic                        rack
);

  localparam logic [SNB_ENTRIES-1:0] ENTRY_ONE = SNB_ENTRIES'(1);

  logic       is_ncq;
  logic       is_snb;
  logic       is_ctc;
  logic [1:0] rack_cnt;
  logic       rack_inc;
  logic       rack_dec;

  // ------------------------------
  // ID decode
  // ------------------------------
  assign is_ncq = !head.id[7];
  assign is_snb = (head.id[7:6] == ebiu_rd_pkg::TAG_SNB);
  assign is_ctc = (head.id[7:6] == ebiu_rd_pkg::TAG_CTC);

  assign ncq_rvalid  = head_valid & is_ncq;
  assign snb0_rvalid = head_valid & is_snb & !head.id[5];
  assign snb1_rvalid = head_valid & is_snb & head.id[5];
  assign ctc_rvalid  = head_valid & is_ctc;

  assign ncq_rid       = head.id;
  assign ctc_rid       = head.id[5:0];
  assign snb_entry_sel = ENTRY_ONE << head.id[4:0];
  assign ret_beat      = head;

  assign pop = ncq_r_grant | snb_r_grant | ctc_r_grant;

  // ------------------------------
  // rack, one cycle per last beat
  // ------------------------------
  assign rack_inc = pop & head.last;
  assign rack_dec = |rack_cnt;

  always_ff @(posedge arctrl_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rack_cnt <= 2'b00;
    else if (rack_inc & !rack_dec)
      rack_cnt <= rack_cnt + 2'b01;
    else if (!rack_inc & rack_dec)
      rack_cnt <= rack_cnt - 2'b01;
  end

  always_ff @(posedge arctrl_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rack <= 1'b0;
    else
      rack <= |rack_cnt;
  end

endmodule

`default_nettype wire

// File: source/ebiu_r_fifo.sv
/*
  Read beat FIFO with registered rready
*/
`timescale 1ns/1ps
`default_nettype none

module ebiu_r_fifo #(
  parameter int RFIFO_DEPTH = 2
) (
  input  wire                         arctrl_clk,
  input  wire                         cpurst_b,
  input  wire                         rvalid,
  input  wire ebiu_axi_pkg::r_beat_t  r_in,
  output logic                        rready,
  output logic                        head_valid,
  output ebiu_axi_pkg::r_beat_t       head,
  input  wire                         pop
);

  localparam int PTR_W = (RFIFO_DEPTH > 1) ? $clog2(RFIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(RFIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(RFIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(RFIFO_DEPTH);

  ebiu_axi_pkg::r_beat_t mem [RFIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  push;
  logic                  pop_en;
  logic                  empty;
  logic                  full;
  logic                  rready_set;

  assign push   = rvalid & rready;
  assign empty  = (count == '0);
  assign full   = (count == FULL_CNT);
  assign pop_en = pop & !empty;

  // ------------------------------
  // Storage and pointers
  // ------------------------------
  always_ff @(posedge arctrl_clk)
  begin
    if (push)
      mem[wr_ptr] <= r_in;
  end

  always_ff @(posedge arctrl_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      if (pop_en)
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      if (push & !pop_en)
        count <= count + 1'b1;
      else if (!push & pop_en)
        count <= count - 1'b1;
    end
  end

  assign head_valid = !empty;
  assign head       = mem[rd_ptr];

  // ------------------------------
  // rready, one cycle ahead of occupancy
  // ------------------------------
  assign rready_set = empty |
                      (!full & (pop_en | !push)) |
                      (full & pop_en & !push);

  always_ff @(posedge arctrl_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rready <= 1'b1;
    else
      rready <= rready_set;
  end

endmodule

`default_nettype wire

// File: source/ebiu_ar_buffer.sv
/*
  One-deep AR holding stage, source ID tagging and AXI AR drive
*/
`timescale 1ns/1ps
`default_nettype none

module ebiu_ar_buffer (
  input  wire                        arctrl_clk,
  input  wire                        cpurst_b,
  input  wire ebiu_rd_pkg::src_sel_t sel,
  input  wire ebiu_rd_pkg::rd_req_t  sel_req,
  input  wire ebiu_rd_pkg::ncq_id_t  ncq_id,
  input  wire ebiu_rd_pkg::sub_id_t  snb_id,
  input  wire ebiu_rd_pkg::sub_id_t  ctc_id,
  output logic                       buf_ready,
  output logic                       arvalid,
  output ebiu_axi_pkg::ar_chan_t     ar,
  input  wire                        arready
);

  logic                  load;
  ebiu_axi_pkg::axi_id_t tag_id;

  // Free slot, or the held entry leaves this cycle
  assign buf_ready = !arvalid | arready;
  assign load      = (|sel) & buf_ready;

  // ------------------------------
  // ID tagging by source
  // ------------------------------
  always_comb
  begin
    case (sel)
      ebiu_rd_pkg::SRC_NCQ: tag_id = {1'b0, ncq_id};
      ebiu_rd_pkg::SRC_SNB: tag_id = {ebiu_rd_pkg::TAG_SNB, snb_id};
      default:              tag_id = {ebiu_rd_pkg::TAG_CTC, ctc_id};
    endcase
  end

  // ------------------------------
  // Holding register
  // ------------------------------
  always_ff @(posedge arctrl_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      arvalid <= 1'b0;
    else if (load)
      arvalid <= 1'b1;
    else if (arready)
      arvalid <= 1'b0;
  end

  always_ff @(posedge arctrl_clk)
  begin
    if (load)
    begin
      ar.id    <= tag_id;
      ar.addr  <= sel_req.addr;
      ar.len   <= sel_req.len;
      ar.size  <= sel_req.size;
      ar.burst <= sel_req.burst;
      ar.lock  <= sel_req.lock;
      ar.cache <= sel_req.cache;
      // Bus sees every read as non-secure
      ar.prot  <= {sel_req.prot[2], 1'b1, sel_req.prot[0]};
    end
  end

endmodule

`default_nettype wire

// File: source/ebiu_ar_arbiter.sv
/*
  Rotating three-way arbiter for the read address channel
*/
`timescale 1ns/1ps
`default_nettype none

module ebiu_ar_arbiter (
  input  wire                       arctrl_clk,
  input  wire                       cpurst_b,
  input  wire                       ncq_valid,
  input  wire                       snb_valid,
  input  wire                       ctc_valid,
  input  wire ebiu_rd_pkg::rd_req_t ncq_req,
  input  wire ebiu_rd_pkg::rd_req_t snb_req,
  input  wire ebiu_rd_pkg::rd_req_t ctc_req,
  input  wire                       buf_ready,
  output logic                      ncq_ar_grant,
  output logic                      snb_ar_grant,
  output logic                      ctc_ar_grant,
  output ebiu_rd_pkg::src_sel_t     sel,
  output ebiu_rd_pkg::rd_req_t      sel_req
);

  ebiu_rd_pkg::src_sel_t rot_ptr;
  logic                  any_valid;
  logic                  ncq_pick;
  logic                  snb_pick;
  logic                  ctc_pick;

  assign any_valid = ncq_valid | snb_valid | ctc_valid;

  // Pointer turns over whenever anyone asks
  always_ff @(posedge arctrl_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rot_ptr <= ebiu_rd_pkg::SRC_NCQ;
    else if (any_valid)
      rot_ptr <= {rot_ptr[1:0], rot_ptr[2]};
  end

  // Own turn, or the only one asking
  assign ncq_pick = ncq_valid & (rot_ptr[0] | (!snb_valid & !ctc_valid));
  assign snb_pick = snb_valid & (rot_ptr[1] | (!ncq_valid & !ctc_valid));
  assign ctc_pick = ctc_valid & (rot_ptr[2] | (!ncq_valid & !snb_valid));

  always_comb
  begin
    sel     = '0;
    sel_req = ncq_req;
    if (ncq_pick)
      sel = ebiu_rd_pkg::SRC_NCQ;
    else if (snb_pick)
    begin
      sel     = ebiu_rd_pkg::SRC_SNB;
      sel_req = snb_req;
    end
    else if (ctc_pick)
    begin
      sel     = ebiu_rd_pkg::SRC_CTC;
      sel_req = ctc_req;
    end
  end

  assign ncq_ar_grant = sel[0] & buf_ready;
  assign snb_ar_grant = sel[1] & buf_ready;
  assign ctc_ar_grant = sel[2] & buf_ready;

endmodule

`default_nettype wire

// File: source/ebiu_rd_pkg.sv
/*
  Requester side ID types, read request struct,
  source select encoding and ID tag prefixes
*/
`default_nettype none

package ebiu_rd_pkg;

  typedef logic [6:0] ncq_id_t;
  typedef logic [5:0] sub_id_t;

  // Request fields without ID, 61 bits
  typedef struct packed {
    ebiu_axi_pkg::addr_t  addr;
    ebiu_axi_pkg::len_t   len;
    ebiu_axi_pkg::size_t  size;
    ebiu_axi_pkg::burst_t burst;
    logic                 lock;
    ebiu_axi_pkg::cache_t cache;
    ebiu_axi_pkg::prot_t  prot;
  } rd_req_t;

  // One-hot source select
  typedef logic [2:0] src_sel_t;

  localparam src_sel_t SRC_NCQ = 3'b001;
  localparam src_sel_t SRC_SNB = 3'b010;
  localparam src_sel_t SRC_CTC = 3'b100;

  // ID prefixes in bits 7..6; ncq only clears bit 7
  localparam logic [1:0] TAG_SNB = 2'b10;
  localparam logic [1:0] TAG_CTC = 2'b11;

endpackage

`default_nettype wire

// File: source/ebiu_axi_pkg.sv
/*
  AXI read field types, AR channel payload and R beat structs
*/
`default_nettype none

package ebiu_axi_pkg;

  // ------------------------------
  // Field widths
  // ------------------------------
  typedef logic [39:0]  addr_t;
  typedef logic [7:0]   axi_id_t;
  typedef logic [7:0]   len_t;
  typedef logic [2:0]   size_t;
  typedef logic [1:0]   burst_t;
  typedef logic [3:0]   cache_t;
  typedef logic [2:0]   prot_t;
  typedef logic [1:0]   resp_t;
  typedef logic [127:0] data_t;

  // ------------------------------
  // Channel payloads
  // ------------------------------
  // AR payload, 69 bits
  typedef struct packed {
    axi_id_t id;
    addr_t   addr;
    len_t    len;
    size_t   size;
    burst_t  burst;
    logic    lock;
    cache_t  cache;
    prot_t   prot;
  } ar_chan_t;

  // One R beat, 139 bits
  typedef struct packed {
    axi_id_t id;
    resp_t   resp;
    logic    last;
    data_t   data;
  } r_beat_t;

endpackage

`default_nettype wire
